// File: flist.f
src/jenc_types_pkg.sv
src/jenc_tables_pkg.sv
src/quant.sv
src/rle_coder.sv
src/bitpacker.sv
src/bytepacker.sv
src/jenc.sv
tb/jenc_sva.sv
tb/tb_jenc.sv

// File: Bender.yml
package:
  name: jenc

sources:
  - src/jenc_types_pkg.sv
  - src/jenc_tables_pkg.sv
  - src/quant.sv
  - src/rle_coder.sv
  - src/bitpacker.sv
  - src/bytepacker.sv
  - src/jenc.sv
  - target: test
    files:
      - tb/jenc_sva.sv
      - tb/tb_jenc.sv

// File: tb/tb_jenc.sv
`timescale 1ns/1ps

module tb_jenc
    import jenc_types_pkg::*;
    import jenc_tables_pkg::*;
();

    localparam int QF_LIST [4] = '{50, 100, 10, 25};
    localparam int WAIT_LIMIT  = 2000;

    logic        clk;
    logic        rst_n;
    logic [1:0]  qf_select;
    coef_t       di;
    logic        di_valid;
    logic        di_last;
    logic        di_hold;
    logic [31:0] out_data;
    logic [2:0]  out_bytes;
    logic        out_tlast;
    logic        out_valid;
    logic        out_hold;
    frame_size_t size;

    logic        hold_en;       // Random back-pressure on the output.
    int          error_cnt;
    coef_t       frame_q[$];
    bit          bit_q[$];
    logic [7:0]  byte_q[$];
    logic [31:0] exp_data_q[$];
    logic [2:0]  exp_bytes_q[$];
    bit          exp_last_q[$];
    frame_size_t exp_size;
    logic [31:0] last_data;
    logic [2:0]  last_bytes;

    jenc #(.QF0(QF_LIST[0]), .QF1(QF_LIST[1]), .QF2(QF_LIST[2]), .QF3(QF_LIST[3])) DUT (.*);

    bind jenc jenc_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        out_hold = 1'b0;
        forever begin
            @(posedge clk);
            out_hold <= hold_en ? ($urandom % 3 == 0) : 1'b0;
        end
    end

    // Bound assertions count their failures.
    always @(negedge clk) begin
        if (DUT.u_sva.fail_cnt != 0) begin
            abort_run("An assertion on the DUT handshake failed.");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string why);
        error_cnt++;
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input logic [31:0] exp_data, input logic [2:0] exp_bytes,
                              input logic [31:0] got_data, input logic [2:0] got_bytes);
        if (got_data !== exp_data) begin
            abort_run($sformatf("MISMATCH time %0t out_data expected %h got %h",
                                $time, exp_data, got_data));
        end else if (got_bytes !== exp_bytes) begin
            abort_run($sformatf("MISMATCH time %0t out_bytes expected %0d got %0d",
                                $time, exp_bytes, got_bytes));
        end
    endtask

    task automatic check_tlast(input bit exp_tlast, input logic got_tlast);
        if (got_tlast !== exp_tlast) begin
            abort_run($sformatf("MISMATCH time %0t out_tlast expected %0b got %0b",
                                $time, exp_tlast, got_tlast));
        end
    endtask

    task automatic check_size(input frame_size_t exp_sz, input frame_size_t got_sz);
        if (got_sz !== exp_sz) begin
            abort_run($sformatf("MISMATCH time %0t size expected %0d got %0d",
                                $time, exp_sz, got_sz));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int quantize(input coef_t c, input int idx, input int qf);
        int mag;
        int q;
        mag = (c < 0) ? -int'(c) : int'(c);
        q   = (mag * int'(q_recip(idx, qf))) >>> 16;   // Truncation rounds toward zero.
        if (c < 0) q = -q;
        if (q > 1023) q = 1023;
        else if (q < -1024) q = -1024;
        return q;
    endfunction

    function automatic int mag_size(input int v);
        int m;
        int s;
        m = (v < 0) ? -v : v;
        s = 0;
        while (m > 0) begin
            s++;
            m = m >> 1;
        end
        return s;
    endfunction

    task automatic put_bits(input int value, input int n);
        for (int b = n - 1; b >= 0; b--) begin
            bit_q.push_back(bit'((value >> b) & 1));
        end
    endtask

    task automatic build_expected(input int qf);
        int          run;
        int          v;
        int          sz;
        int          cnt;
        logic [7:0]  b8;
        logic [31:0] w;
        bit_q.delete();
        byte_q.delete();
        exp_data_q.delete();
        exp_bytes_q.delete();
        exp_last_q.delete();
        run = 0;
        for (int k = 0; k < frame_q.size(); k++) begin
            if (k % 64 == 0) run = 0;
            v = quantize(frame_q[k], k % 64, qf);
            if (v == 0) begin
                run++;
                if (k % 64 == 63) put_bits(8'h00, 8);   // EOB drops the pending zeros.
            end else begin
                while (run >= 16) begin
                    put_bits(8'hF0, 8);
                    run -= 16;
                end
                sz = mag_size(v);
                put_bits(((run % 16) << 4) | sz, 8);
                put_bits((v < 0) ? v - 1 : v, sz);
                run = 0;
            end
        end
        put_bits(8'hFF, 8 - (bit_q.size() % 8));        // One to eight 1-bits close the frame.
        for (int k = 0; k < bit_q.size(); k += 8) begin
            b8 = '0;
            for (int j = 0; j < 8; j++) begin
                b8 = {b8[6:0], bit_q[k + j]};
            end
            byte_q.push_back(b8);
            if (b8 == 8'hFF) byte_q.push_back(8'h00);
        end
        exp_size = frame_size_t'(byte_q.size());
        for (int k = 0; k < byte_q.size(); k += 4) begin
            w   = '0;
            cnt = 0;
            for (int j = 0; j < 4 && k + j < byte_q.size(); j++) begin
                w[31 - 8 * j -: 8] = byte_q[k + j];
                cnt++;
            end
            exp_data_q.push_back(w);
            exp_bytes_q.push_back(3'(cnt));
            exp_last_q.push_back(k + 4 >= byte_q.size());
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and collection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_frame();
        int waited;
        for (int k = 0; k < frame_q.size(); k++) begin
            di       <= frame_q[k];
            di_valid <= 1'b1;
            di_last  <= (k == frame_q.size() - 1);
            waited = 0;
            @(negedge clk);
            while (di_hold) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("Timeout: the DUT kept its input on hold.");
                end
                @(negedge clk);
            end
            @(posedge clk);                                // Transfer happens on this edge.
        end
        di_valid <= 1'b0;
        di_last  <= 1'b0;
    endtask

    task automatic collect_frame();
        int waited;
        bit done;
        done = 1'b0;
        while (!done) begin
            waited = 0;
            @(negedge clk);
            while (!(out_valid && !out_hold)) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run("Timeout: no output word came from the DUT.");
                end
                @(negedge clk);
            end
            if (exp_data_q.size() == 0) abort_run("The DUT sent more words than expected.");
            check_word(exp_data_q.pop_front(), exp_bytes_q.pop_front(), out_data, out_bytes);
            check_tlast(exp_last_q.pop_front(), out_tlast);
            last_data  = out_data;
            last_bytes = out_bytes;
            done       = out_tlast;
        end
    endtask

    task automatic run_frame(input logic [1:0] qsel);
        build_expected(QF_LIST[qsel]);
        @(posedge clk);
        qf_select <= qsel;
        fork
            send_frame();
            collect_frame();
        join
        @(negedge clk);
        check_size(exp_size, size);
    endtask

    task automatic fill_random(input int blocks);
        frame_q.delete();
        for (int k = 0; k < 64 * blocks; k++) begin
            if (($urandom % 64) > (k % 64)) begin
                frame_q.push_back(coef_t'(int'($urandom % 4001) - 2000));
            end else begin
                frame_q.push_back('0);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_zero_block();
        frame_q.delete();
        repeat (64) frame_q.push_back('0);
        run_frame(2'd0);
        check_word(32'h00FF0000, 3'd3, last_data, last_bytes);
        check_size(20'd3, size);
    endtask

    task automatic test_single_coef(input coef_t value);
        frame_q.delete();
        for (int k = 0; k < 64; k++) begin
            frame_q.push_back((k == 40) ? value : coef_t'(0));
        end
        run_frame(2'd0);
        check_size(20'd5, size);        // Two ZRLs, symbol, amplitude, EOB and padding.
    endtask

    task automatic test_qf_sweep();
        fill_random(1);
        for (int s = 0; s < 4; s++) begin
            run_frame(2'(s));
        end
    endtask

    task automatic test_stuffing();
        frame_q.delete();
        for (int k = 0; k < 64; k++) begin
            frame_q.push_back((k < 4) ? coef_t'(255) : coef_t'(0));
        end
        run_frame(2'd1);
        check_size(20'd15, size);
    endtask

    task automatic test_backpressure();
        fill_random(3);
        hold_en = 1'b1;
        run_frame(2'd1);
        hold_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h62e4));
        error_cnt = 0;
        hold_en   = 1'b0;
        rst_n     = 1'b0;
        qf_select = 2'd0;
        di        = '0;
        di_valid  = 1'b0;
        di_last   = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_size(20'd0, size);
        test_zero_block();
        test_single_coef(coef_t'(700));
        test_single_coef(coef_t'(-700));
        test_qf_sweep();
        test_stuffing();
        test_backpressure();
        if (error_cnt == 0 && DUT.u_sva.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb/jenc_sva.sv
`timescale 1ns/1ps

module jenc_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        di_hold,
    input logic [31:0] out_data,
    input logic [2:0]  out_bytes,
    input logic        out_tlast,
    input logic        out_valid,
    input logic        out_hold,
    input logic [19:0] size
);

    int fail_cnt = 0;    // Failed assertions so far.

    // Handshake outputs stay quiet while reset is applied.
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid && !di_hold)
        else begin
            fail_cnt++;
            $error("Valid or hold output active during reset.");
        end

    a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_hold |=> out_valid && $stable(out_data) && $stable(out_bytes)
                                  && $stable(out_tlast))
        else begin
            fail_cnt++;
            $error("Output word changed while held.");
        end

    a_full_words: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_tlast |-> out_bytes == 3'd4)
        else begin
            fail_cnt++;
            $error("Short word before the end of the frame.");
        end

    // Size moves only when the closing word of a frame is taken.
    a_size_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_valid && !out_hold && out_tlast) |=> $stable(size))
        else begin
            fail_cnt++;
            $error("Frame size changed outside a frame end.");
        end

endmodule

// File: src/jenc.sv
`timescale 1ns/1ps

module jenc
    import jenc_types_pkg::*;
#(
    parameter int QF0 = 50,
    parameter int QF1 = 100,
    parameter int QF2 = 10,
    parameter int QF3 = 25
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  qf_select,    // Held constant for a whole frame.
    input  coef_t       di,
    input  logic        di_valid,
    input  logic        di_last,
    output logic        di_hold,
    output logic [31:0] out_data,
    output logic [2:0]  out_bytes,
    output logic        out_tlast,
    output logic        out_valid,
    input  logic        out_hold,
    output frame_size_t size
);

    qcoef_t     q_data;
    logic       q_valid;
    logic       q_last;
    logic       q_hold;
    code_word_t cw;
    logic       cw_valid;
    logic       cw_hold;
    byte_grp_t  bg;
    logic       bg_valid;
    logic       bg_hold;

    // Each hold reaching a stage is qualified by that stage's own valid.
    quant #(.QF0(QF0), .QF1(QF1), .QF2(QF2), .QF3(QF3)) quant (
        .q_hold     (q_hold & q_valid),
        .*
    );

    rle_coder rle_coder (
        .cw_hold    (cw_hold & cw_valid),
        .*
    );

    bitpacker bitpacker (
        .bg_hold    (bg_hold & bg_valid),
        .*
    );

    bytepacker bytepacker (
        .out_hold   (out_hold & out_valid),
        .*
    );

endmodule

// File: src/bytepacker.sv
`timescale 1ns/1ps

module bytepacker
    import jenc_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  byte_grp_t   bg,
    input  logic        bg_valid,
    output logic        bg_hold,
    output logic [31:0] out_data,
    output logic [2:0]  out_bytes,
    output logic        out_tlast,
    output logic        out_valid,
    input  logic        out_hold,
    output frame_size_t size
);

    logic [1:0]  ptr;
    logic        stuff;      // A 0x00 is owed after the byte at ptr.
    logic [7:0]  cur_byte;
    logic [7:0]  byte_out;
    logic        step;
    logic        advance;
    logic        grp_end;
    logic        frame_end;
    logic [31:0] wbuf;
    logic [31:0] wbuf_nx;
    logic [1:0]  wcnt;
    logic [2:0]  wcnt_nx;
    logic        word_done;
    frame_size_t frame_cnt;

    assign cur_byte  = bg.data[8 * (3 - ptr) +: 8];
    assign step      = bg_valid & ~out_hold;
    assign byte_out  = stuff ? 8'h00 : cur_byte;
    assign advance   = step & (stuff | (cur_byte != 8'hFF));
    assign grp_end   = ((3'(ptr) + 3'd1) == bg.bytes);
    assign frame_end = advance & grp_end & bg.last;
    assign bg_hold   = bg_valid & ~(advance & grp_end);
    assign wbuf_nx   = {wbuf[23:0], byte_out};
    assign wcnt_nx   = 3'(wcnt) + 3'd1;
    assign word_done = step & ((wcnt_nx == 3'd4) | frame_end);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr       <= '0;
            stuff     <= 1'b0;
            wcnt      <= '0;
            out_valid <= 1'b0;
            frame_cnt <= '0;
            size      <= '0;
        end else begin
            if (step) begin
                stuff <= ~stuff & (cur_byte == 8'hFF);
                wcnt  <= word_done ? 2'd0 : wcnt_nx[1:0];
                if (advance) begin
                    ptr <= grp_end ? 2'd0 : ptr + 2'd1;
                end
            end
            if (!out_hold) begin
                out_valid <= word_done;
            end
            if (out_valid && !out_hold) begin
                if (out_tlast) begin
                    size      <= frame_cnt + frame_size_t'(out_bytes);
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + frame_size_t'(out_bytes);
                end
            end
        end
    end

    // Shifting left aligns a short final word and drops stale bytes.
    always_ff @(posedge clk) begin
        if (step) begin
            wbuf <= wbuf_nx;
        end
        if (word_done) begin
            out_data  <= wbuf_nx << (8 * (4 - wcnt_nx));
            out_bytes <= wcnt_nx;
            out_tlast <= frame_end;
        end
    end

endmodule

// File: src/bitpacker.sv
`timescale 1ns/1ps

module bitpacker
    import jenc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  code_word_t cw,
    input  logic       cw_valid,
    output logic       cw_hold,
    output byte_grp_t  bg,
    output logic       bg_valid,
    input  logic       bg_hold
);

    logic [63:0] acc;         // Valid bits start at bit 63.
    logic [6:0]  nbits;
    logic        flush;
    logic        take;
    logic        emit;
    logic        final_grp;
    logic [6:0]  shamt;
    logic [63:0] acc_pad;
    logic [2:0]  nbytes;

    // At most 31 bits wait when a code arrives, so a 19 bit code always fits.
    assign cw_hold   = flush | (nbits >= 7'd32);
    assign take      = cw_valid & ~cw_hold;
    assign emit      = ~bg_hold & (flush | (nbits >= 7'd32));
    assign final_grp = flush & (nbits < 7'd32);
    assign shamt     = 7'd64 - nbits - 7'(cw.len);

    // Padding always adds one to eight 1-bits after the final code.
    assign acc_pad   = acc | ({64{1'b1}} >> nbits);
    assign nbytes    = 3'(nbits[6:3] + 4'd1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            nbits    <= '0;
            flush    <= 1'b0;
            bg_valid <= 1'b0;
        end else begin
            if (!bg_hold) begin
                bg_valid <= flush | (nbits >= 7'd32);
            end
            if (take) begin
                acc   <= acc | (64'(cw.bits) << shamt);
                nbits <= nbits + 7'(cw.len);
                flush <= cw.last;
            end else if (emit) begin
                if (final_grp) begin
                    acc   <= '0;
                    nbits <= '0;
                    flush <= 1'b0;
                end else begin
                    acc   <= acc << 32;
                    nbits <= nbits - 7'd32;
                end
            end
        end
    end

    // The pad mask only touches bits below the fill level.
    always_ff @(posedge clk) begin
        if (emit) begin
            bg.data  <= acc_pad[63:32];
            bg.bytes <= final_grp ? nbytes : 3'd4;
            bg.last  <= final_grp;
        end
    end

endmodule

// File: src/rle_coder.sv
`timescale 1ns/1ps

module rle_coder
    import jenc_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  qcoef_t     q_data,
    input  logic       q_valid,
    input  logic       q_last,
    output logic       q_hold,
    output code_word_t cw,
    output logic       cw_valid,
    input  logic       cw_hold
);

    localparam logic [7:0] ZRL_SYM = 8'hF0;
    localparam logic [7:0] EOB_SYM = 8'h00;

    rle_state_t  state;
    rle_state_t  state_nx;
    logic [5:0]  run;
    logic [5:0]  run_nx;
    zz_idx_t     blk_idx;
    logic        eob_last;
    logic        is_zero;
    logic        blk_end;
    logic        take;
    logic        emit;
    logic [10:0] mag;
    logic [10:0] amp;
    logic [10:0] amp_bits;
    logic [3:0]  size;
    code_word_t  code_cw;
    code_word_t  cw_nx;

    assign is_zero  = (q_data == '0);
    assign blk_end  = (blk_idx == 6'd63);
    assign take     = q_valid & ~q_hold;
    assign mag      = q_data[10] ? 11'(-q_data) : 11'(q_data);
    assign amp      = q_data[10] ? 11'(q_data) - 11'd1 : 11'(q_data);
    assign amp_bits = amp & ~(11'h7FF << size);

    always_comb begin
        size = 4'd0;
        for (int b = 0; b < 11; b++) begin
            if (mag[b]) size = 4'(b + 1);   // Magnitude category.
        end
    end

    always_comb begin
        code_cw.len  = 5'd8 + 5'(size);
        code_cw.bits = (code_bits_t'({run[3:0], size}) << size) | code_bits_t'(amp_bits);
        code_cw.last = q_last;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nx = state;
        run_nx   = run;
        emit     = 1'b0;
        cw_nx    = code_cw;
        q_hold   = 1'b1;
        case (state)
            RLE_IDLE_RUN: begin
                if (is_zero) begin
                    q_hold = 1'b0;                   // Zeros never need the output.
                    if (q_valid) begin
                        run_nx   = blk_end ? 6'd0 : run + 6'd1;
                        state_nx = blk_end ? RLE_EOB : RLE_IDLE_RUN;
                    end
                end else if (run >= 6'd16) begin
                    if (q_valid && !cw_hold) begin
                        emit     = 1'b1;
                        cw_nx    = '{len: 5'd8, bits: code_bits_t'(ZRL_SYM), last: 1'b0};
                        run_nx   = run - 6'd16;
                        state_nx = (run >= 6'd32) ? RLE_ZRL : RLE_CODE;
                    end
                end else begin
                    q_hold = cw_hold;
                    emit   = q_valid & ~cw_hold;
                    run_nx = (q_valid && !cw_hold) ? 6'd0 : run;
                end
            end
            RLE_ZRL: begin
                if (!cw_hold) begin
                    emit     = 1'b1;
                    cw_nx    = '{len: 5'd8, bits: code_bits_t'(ZRL_SYM), last: 1'b0};
                    run_nx   = run - 6'd16;
                    state_nx = (run >= 6'd32) ? RLE_ZRL : RLE_CODE;
                end
            end
            RLE_CODE: begin
                q_hold = cw_hold;                    // The coefficient leaves with its code.
                if (!cw_hold) begin
                    emit     = 1'b1;
                    run_nx   = 6'd0;
                    state_nx = RLE_IDLE_RUN;
                end
            end
            RLE_EOB: begin
                if (!cw_hold) begin
                    emit     = 1'b1;
                    cw_nx    = '{len: 5'd8, bits: code_bits_t'(EOB_SYM), last: eob_last};
                    state_nx = RLE_IDLE_RUN;
                end
            end
            default: state_nx = RLE_IDLE_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RLE_IDLE_RUN;
            run      <= '0;
            blk_idx  <= '0;
            eob_last <= 1'b0;
            cw_valid <= 1'b0;
        end else begin
            state <= state_nx;
            run   <= run_nx;
            if (take) begin
                blk_idx <= blk_idx + 1'b1;
            end
            if (take && is_zero && blk_end) begin
                eob_last <= q_last;
            end
            if (!cw_hold) begin
                cw_valid <= emit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            cw <= cw_nx;
        end
    end

endmodule

// File: src/quant.sv
`timescale 1ns/1ps

module quant
    import jenc_types_pkg::*;
    import jenc_tables_pkg::*;
#(
    parameter int QF0 = 50,
    parameter int QF1 = 100,
    parameter int QF2 = 10,
    parameter int QF3 = 25
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] qf_select,
    input  coef_t      di,
    input  logic       di_valid,
    input  logic       di_last,
    output logic       di_hold,
    output qcoef_t     q_data,
    output logic       q_valid,
    output logic       q_last,
    input  logic       q_hold
);

    localparam int QF_SET [4] = '{QF0, QF1, QF2, QF3};

    logic [16:0] recip_tab [4][64];
    zz_idx_t     idx;
    logic [11:0] di_mag;
    logic [28:0] s1_prod;
    logic        s1_neg;
    logic        s1_last;
    logic        s1_valid;
    logic [12:0] s2_mag;
    qcoef_t      q_nx;

    for (genvar g = 0; g < 4; g++) begin : g_qf
        for (genvar i = 0; i < 64; i++) begin : g_idx
            assign recip_tab[g][i] = q_recip(i, QF_SET[g]);
        end
    end

    assign di_hold = q_hold;                                // Both stages stall as one.
    assign di_mag  = di[11] ? 12'(-di) : 12'(di);
    assign s2_mag  = s1_prod[28:16];

    // Magnitude is truncated before the sign returns, so rounding is toward zero.
    always_comb begin
        if (!s1_neg) begin
            q_nx = (s2_mag > 13'd1023) ? qcoef_t'(11'h3FF) : qcoef_t'(s2_mag[10:0]);
        end else begin
            q_nx = (s2_mag > 13'd1024) ? qcoef_t'(11'h400) : qcoef_t'(11'(13'd0 - s2_mag));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= '0;
            s1_valid <= 1'b0;
            q_valid  <= 1'b0;
        end else if (!q_hold) begin
            s1_valid <= di_valid;
            q_valid  <= s1_valid;
            if (di_valid) begin
                idx <= di_last ? '0 : idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!q_hold) begin
            s1_prod <= di_mag * recip_tab[qf_select][idx];
            s1_neg  <= di[11];
            s1_last <= di_last;
            q_data  <= q_nx;
            q_last  <= s1_last;
        end
    end

endmodule

// File: src/jenc_tables_pkg.sv
package jenc_tables_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Luminance quantisation, stored in zigzag order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [7:0] QBASE [64] = '{
        16,  11,  12,  14,  12,  10,  16,  14,
        13,  14,  18,  17,  16,  19,  24,  40,
        26,  24,  22,  22,  24,  49,  35,  37,
        29,  40,  58,  51,  61,  60,  57,  51,
        56,  55,  64,  72,  92,  78,  64,  68,
        87,  69,  55,  56,  80, 109,  81,  87,
        95,  98, 103, 104, 103,  62,  77, 113,
        121, 112, 100, 120,  92, 101, 103,  99
    };

    function automatic logic [7:0] q_step(input int idx, input int qf);
        int qf_c;
        int scale;
        int q;
        qf_c  = (qf < 1) ? 1 : ((qf > 100) ? 100 : qf);
        scale = (qf_c < 50) ? 5000 / qf_c : 200 - 2 * qf_c;   // IJG quality scaling in percent.
        q     = (int'(QBASE[idx]) * scale + 50) / 100;
        if (q < 1) q = 1;
        else if (q > 255) q = 255;
        return 8'(q);
    endfunction

    // A step of 1 gives 65536, hence the 17th bit.
    function automatic logic [16:0] q_recip(input int idx, input int qf);
        return 17'(65536 / int'(q_step(idx, qf)));
    endfunction

endpackage

// File: src/jenc_types_pkg.sv
package jenc_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Coefficient and code widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic signed [11:0] coef_t;         // DCT coefficient in zigzag order.
    typedef logic signed [10:0] qcoef_t;        // Quantised coefficient.
    typedef logic [5:0]         zz_idx_t;       // Position inside the 8x8 block.
    typedef logic [4:0]         code_len_t;     // 8 symbol bits plus up to 11 amplitude bits.
    typedef logic [18:0]        code_bits_t;    // Right aligned, unused high bits are zero.
    typedef logic [19:0]        frame_size_t;   // Output bytes per frame.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        code_len_t  len;
        code_bits_t bits;
        logic       last;    // Final code of the frame.
    } code_word_t;

    typedef struct packed {
        logic [31:0] data;   // First byte sits in bits 31:24.
        logic [2:0]  bytes;  // Valid bytes, 1 to 4.
        logic        last;
    } byte_grp_t;

    // Zero run coder states.
    typedef enum logic [1:0] {
        RLE_IDLE_RUN,
        RLE_ZRL,
        RLE_CODE,
        RLE_EOB
    } rle_state_t;

endpackage
